// File: design/dma_qs_pkg.sv
package dma_qs_pkg;

    localparam int DATA_W     = 32;
    localparam int QS_ADDR_W  = 24;
    localparam int WORD_COUNT = 10;
    localparam int WORD_BYTES = 4;  // Byte step between consecutive words

    // Wishbone register offsets, decoded on adr[7:0]
    localparam logic [7:0] REG_CTRL = 8'h00;  // Start on write, status on read
    localparam logic [7:0] REG_BASE = 8'h04;

    // Status register bits
    localparam int STAT_DONE_BIT = 1;  // Sticky, cleared by a status read
    localparam int STAT_IDLE_BIT = 2;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [QS_ADDR_W-1:0] qs_addr_t;
    typedef logic [3:0]           word_idx_t;  // Holds 0..WORD_COUNT

endpackage

// File: design/dma_wb_regs.sv
`timescale 1ns/100ps

module dma_wb_regs (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_we_i,
    input  logic [3:0]           wbs_sel_i,
    input  dma_qs_pkg::data_t    wbs_dat_i,
    input  logic [31:0]          wbs_adr_i,
    input  logic                 job_done_i,
    output logic                 wbs_ack_o,
    output dma_qs_pkg::data_t    wbs_dat_o,
    output logic                 job_start_o,
    output dma_qs_pkg::qs_addr_t base_addr_o
);
    import dma_qs_pkg::*;

    logic  req;
    logic  wr_base;
    logic  wr_start;
    logic  rd_ctrl;
    logic  base_valid;
    logic  busy;
    logic  done_q;
    logic  start_pend;
    data_t rdata;

    assign req      = wbs_stb_i & wbs_cyc_i & ~wbs_ack_o;
    assign wr_base  = req & wbs_we_i & (wbs_adr_i[7:0] == REG_BASE) & ~busy;
    assign wr_start = req & wbs_we_i & (wbs_adr_i[7:0] == REG_CTRL) & wbs_sel_i[0]
                    & wbs_dat_i[0] & base_valid & ~busy;
    assign rd_ctrl  = req & ~wbs_we_i & (wbs_adr_i[7:0] == REG_CTRL);

    always_comb begin
        rdata = '0;
        case (wbs_adr_i[7:0])
            REG_CTRL: begin
                rdata[STAT_DONE_BIT] = done_q;
                rdata[STAT_IDLE_BIT] = ~busy;
            end
            REG_BASE: rdata = {{(DATA_W-QS_ADDR_W){1'b0}}, base_addr_o};
            default:  rdata = '0;  // Unmapped offsets read as zero
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o   <= 1'b0;
            wbs_dat_o   <= '0;
            base_valid  <= 1'b0;
            busy        <= 1'b0;
            done_q      <= 1'b0;
            start_pend  <= 1'b0;
            job_start_o <= 1'b0;
        end else begin
            wbs_ack_o   <= req;
            wbs_dat_o   <= (req & ~wbs_we_i) ? rdata : '0;
            start_pend  <= wr_start;   // High together with the ack
            job_start_o <= start_pend; // Engine start follows the ack cycle
            if (wr_base && (wbs_sel_i[2:0] != 3'b000))
                base_valid <= 1'b1;
            if (wr_start)
                busy <= 1'b1;
            else if (job_done_i)
                busy <= 1'b0;
            if (job_done_i)
                done_q <= 1'b1;        // Set wins over a clearing read
            else if (rd_ctrl)
                done_q <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        for (int b = 0; b < QS_ADDR_W / 8; b++) begin
            if (wr_base && wbs_sel_i[b])
                base_addr_o[8*b +: 8] <= wbs_dat_i[8*b +: 8];
        end
    end

    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |=> !wbs_ack_o);

endmodule

// File: design/dma_fetch.sv
`timescale 1ns/100ps

module dma_fetch (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 job_start_i,
    input  dma_qs_pkg::qs_addr_t base_addr_i,
    input  logic                 rd_gnt_i,
    input  logic                 rd_cmpl_i,
    input  dma_qs_pkg::data_t    rd_data_i,
    input  logic                 ss_tready_i,
    output logic                 rd_req_o,
    output dma_qs_pkg::qs_addr_t rd_addr_o,
    output logic                 rd_prefetch_o,
    output logic                 ss_tvalid_o,
    output dma_qs_pkg::data_t    ss_tdata_o
);
    import dma_qs_pkg::*;

    word_idx_t cnt;        // Words read so far in this job
    logic      active;
    logic      in_flight;
    logic      buf_valid;
    data_t     in_buf;

    // One word in flight at most, next read waits for the stream to take the buffer
    assign rd_req_o      = active & ~buf_valid & ~in_flight;
    assign rd_addr_o     = base_addr_i + qs_addr_t'(cnt) * qs_addr_t'(WORD_BYTES);
    assign rd_prefetch_o = (cnt != '0);
    assign ss_tvalid_o   = buf_valid;
    assign ss_tdata_o    = in_buf;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cnt       <= '0;
            active    <= 1'b0;
            in_flight <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (job_start_i) begin
                cnt    <= '0;
                active <= 1'b1;
            end
            if (rd_gnt_i)
                in_flight <= 1'b1;
            if (rd_cmpl_i) begin
                in_flight <= 1'b0;
                buf_valid <= 1'b1;
                cnt       <= cnt + 1'b1;
                if (cnt == word_idx_t'(WORD_COUNT - 1))
                    active <= 1'b0;    // Last word fetched
            end else if (buf_valid && ss_tready_i) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rd_cmpl_i)
            in_buf <= rd_data_i;
    end

    a_ss_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ss_tvalid_o && !ss_tready_i |=> ss_tvalid_o && $stable(ss_tdata_o));

endmodule

// File: design/dma_drain.sv
`timescale 1ns/100ps

module dma_drain (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 job_start_i,
    input  dma_qs_pkg::qs_addr_t base_addr_i,
    input  logic                 wr_gnt_i,
    input  logic                 wr_cmpl_i,
    input  logic                 sm_tvalid_i,
    input  dma_qs_pkg::data_t    sm_tdata_i,
    input  logic                 qs_done_i,
    output logic                 wr_req_o,
    output dma_qs_pkg::qs_addr_t wr_addr_o,
    output dma_qs_pkg::data_t    wr_data_o,
    output logic                 sm_tready_o,
    output logic                 job_done_o
);
    import dma_qs_pkg::*;

    word_idx_t wr_cnt;     // Results written back so far
    logic      active;
    logic      in_flight;
    logic      obuf_valid;
    logic      done_seen;
    data_t     out_buf;

    assign sm_tready_o = active & ~obuf_valid;  // Back-pressure while buffer full
    assign wr_req_o    = obuf_valid & ~in_flight;
    assign wr_addr_o   = base_addr_i + qs_addr_t'(wr_cnt) * qs_addr_t'(WORD_BYTES);
    assign wr_data_o   = out_buf;
    // Buffer drains only on write completion, so empty means nothing outstanding
    assign job_done_o  = active & done_seen & ~obuf_valid;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wr_cnt     <= '0;
            active     <= 1'b0;
            in_flight  <= 1'b0;
            obuf_valid <= 1'b0;
            done_seen  <= 1'b0;
        end else begin
            if (job_start_i) begin
                wr_cnt    <= '0;
                active    <= 1'b1;
                done_seen <= 1'b0;
            end else if (job_done_o) begin
                active <= 1'b0;
            end else if (active && qs_done_i) begin
                done_seen <= 1'b1;
            end
            if (sm_tvalid_i && sm_tready_o)
                obuf_valid <= 1'b1;
            if (wr_gnt_i)
                in_flight <= 1'b1;
            if (wr_cmpl_i) begin
                in_flight  <= 1'b0;
                obuf_valid <= 1'b0;
                wr_cnt     <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (sm_tvalid_i && sm_tready_o)
            out_buf <= sm_tdata_i;
    end

    a_wr_limit: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wr_gnt_i |-> wr_cnt < word_idx_t'(WORD_COUNT));

endmodule

// File: design/dma_sdram_arb.sv
`timescale 1ns/100ps

module dma_sdram_arb (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 rd_req_i,
    input  dma_qs_pkg::qs_addr_t rd_addr_i,
    input  logic                 rd_prefetch_i,
    input  logic                 wr_req_i,
    input  dma_qs_pkg::qs_addr_t wr_addr_i,
    input  dma_qs_pkg::data_t    wr_data_i,
    input  dma_qs_pkg::data_t    qs_rdata_i,
    input  logic                 qs_busy_i,
    input  logic                 qs_out_valid_i,
    output logic                 rd_gnt_o,
    output logic                 rd_cmpl_o,
    output dma_qs_pkg::data_t    rd_data_o,
    output logic                 wr_gnt_o,
    output logic                 wr_cmpl_o,
    output dma_qs_pkg::qs_addr_t qs_address_o,
    output logic                 qs_rw_o,
    output dma_qs_pkg::data_t    qs_wdata_o,
    output logic                 qs_in_valid_o,
    output logic                 qs_prefetch_step_o
);
    import dma_qs_pkg::*;

    logic outstanding;
    logic owner_wr;   // High while drain owns the current access
    logic issue;

    assign issue     = (rd_req_i | wr_req_i) & ~outstanding & ~qs_busy_i;
    assign wr_gnt_o  = issue & wr_req_i;            // Drain wins a tie
    assign rd_gnt_o  = issue & ~wr_req_i;
    assign wr_cmpl_o = qs_out_valid_i & outstanding & owner_wr;
    assign rd_cmpl_o = qs_out_valid_i & outstanding & ~owner_wr;
    assign rd_data_o = qs_rdata_i;
    assign qs_rw_o   = owner_wr;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            outstanding        <= 1'b0;
            owner_wr           <= 1'b0;
            qs_in_valid_o      <= 1'b0;
            qs_prefetch_step_o <= 1'b0;
        end else begin
            qs_in_valid_o <= issue;
            if (issue) begin
                outstanding        <= 1'b1;
                owner_wr           <= wr_req_i;
                qs_prefetch_step_o <= ~wr_req_i & rd_prefetch_i;
            end else if (qs_out_valid_i) begin
                outstanding <= 1'b0;
            end
        end
    end

    // Address and data stay put until the controller completes
    always_ff @(posedge wb_clk_i) begin
        if (issue) begin
            qs_address_o <= wr_req_i ? wr_addr_i : rd_addr_i;
            qs_wdata_o   <= wr_req_i ? wr_data_i : '0;
        end
    end

    a_one_access: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        qs_in_valid_o |-> !qs_busy_i);

endmodule

// File: design/dma_qs_top.sv
`timescale 1ns/100ps

module dma_qs_top (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_we_i,
    input  logic [3:0]           wbs_sel_i,
    input  dma_qs_pkg::data_t    wbs_dat_i,
    input  logic [31:0]          wbs_adr_i,
    output logic                 wbs_ack_o,
    output dma_qs_pkg::data_t    wbs_dat_o,
    output dma_qs_pkg::qs_addr_t qs_address_o,
    output logic                 qs_rw_o,
    output dma_qs_pkg::data_t    qs_wdata_o,
    input  dma_qs_pkg::data_t    qs_rdata_i,
    input  logic                 qs_busy_i,
    output logic                 qs_in_valid_o,
    input  logic                 qs_out_valid_i,
    output logic                 qs_prefetch_step_o,
    output logic                 qs_start_o,
    input  logic                 qs_done_i,
    output logic                 ss_tvalid_o,
    output dma_qs_pkg::data_t    ss_tdata_o,
    input  logic                 ss_tready_i,
    input  logic                 sm_tvalid_i,
    input  dma_qs_pkg::data_t    sm_tdata_i,
    output logic                 sm_tready_o
);
    import dma_qs_pkg::*;

    logic     job_start;
    logic     job_done;
    qs_addr_t base_addr;
    logic     rd_req;
    qs_addr_t rd_addr;
    logic     rd_prefetch;
    logic     rd_gnt;
    logic     rd_cmpl;
    data_t    rd_data;
    logic     wr_req;
    qs_addr_t wr_addr;
    data_t    wr_data;
    logic     wr_gnt;
    logic     wr_cmpl;

    assign qs_start_o = job_start;

    dma_wb_regs i_dma_wb_regs (
        .wb_clk_i, .wb_rst_i,
        .wbs_stb_i, .wbs_cyc_i, .wbs_we_i, .wbs_sel_i, .wbs_dat_i, .wbs_adr_i,
        .job_done_i (job_done),
        .wbs_ack_o, .wbs_dat_o,
        .job_start_o(job_start),
        .base_addr_o(base_addr)
    );

    dma_fetch i_dma_fetch (
        .wb_clk_i, .wb_rst_i,
        .job_start_i  (job_start),
        .base_addr_i  (base_addr),
        .rd_gnt_i     (rd_gnt),
        .rd_cmpl_i    (rd_cmpl),
        .rd_data_i    (rd_data),
        .ss_tready_i,
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .rd_prefetch_o(rd_prefetch),
        .ss_tvalid_o, .ss_tdata_o
    );

    dma_drain i_dma_drain (
        .wb_clk_i, .wb_rst_i,
        .job_start_i(job_start),
        .base_addr_i(base_addr),
        .wr_gnt_i   (wr_gnt),
        .wr_cmpl_i  (wr_cmpl),
        .sm_tvalid_i, .sm_tdata_i, .qs_done_i,
        .wr_req_o   (wr_req),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .sm_tready_o,
        .job_done_o (job_done)
    );

    dma_sdram_arb i_dma_sdram_arb (
        .wb_clk_i, .wb_rst_i,
        .rd_req_i     (rd_req),
        .rd_addr_i    (rd_addr),
        .rd_prefetch_i(rd_prefetch),
        .wr_req_i     (wr_req),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .qs_rdata_i, .qs_busy_i, .qs_out_valid_i,
        .rd_gnt_o     (rd_gnt),
        .rd_cmpl_o    (rd_cmpl),
        .rd_data_o    (rd_data),
        .wr_gnt_o     (wr_gnt),
        .wr_cmpl_o    (wr_cmpl),
        .qs_address_o, .qs_rw_o, .qs_wdata_o, .qs_in_valid_o, .qs_prefetch_step_o
    );

endmodule

// File: dv/tb_models.sv
`timescale 1ns/100ps

module sdram_model #(
    parameter int SEED = 32'h26e232eb
) (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  dma_qs_pkg::qs_addr_t address_i,
    input  logic                 rw_i,
    input  dma_qs_pkg::data_t    wdata_i,
    input  logic                 in_valid_i,
    output dma_qs_pkg::data_t    rdata_o,
    output logic                 busy_o,
    output logic                 out_valid_o
);
    import dma_qs_pkg::*;

    data_t    mem [0:63];
    int       seed;
    int       left;       // Busy cycles still to go, 0 when idle
    qs_addr_t acc_addr;
    logic     acc_rw;
    data_t    acc_wdata;

    initial begin
        seed        = SEED;
        left        = 0;
        rdata_o     = '0;
        busy_o      = 1'b0;
        out_valid_o = 1'b0;
        for (int i = 0; i < 64; i++)
            mem[i] = data_t'(i + 1) * 32'h9e3779b1;  // Odd multiplier keeps words distinct
        forever begin
            @(posedge wb_clk_i);
            if (wb_rst_i) begin
                left = 0;
            end else if (in_valid_i) begin
                acc_addr  = address_i;
                acc_rw    = rw_i;
                acc_wdata = wdata_i;
                left      = 1 + ($random(seed) & 3);  // 1 to 4 busy cycles
            end else if (left > 0) begin
                left = left - 1;
            end
            #1;
            busy_o      = (left > 0);
            out_valid_o = (left == 1);
            if (left == 1) begin
                if (acc_rw)
                    mem[acc_addr[7:2]] = acc_wdata;
                else
                    rdata_o = mem[acc_addr[7:2]];
            end
        end
    end

endmodule

module sort_engine_model #(
    parameter int SEED = 32'h26e232eb
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              start_i,
    input  logic              ss_tvalid_i,
    input  dma_qs_pkg::data_t ss_tdata_i,
    output logic              ss_tready_o,
    output logic              sm_tvalid_o,
    output dma_qs_pkg::data_t sm_tdata_o,
    input  logic              sm_tready_i,
    output logic              done_o
);
    import dma_qs_pkg::*;

    data_t words [WORD_COUNT];
    int    seed;
    int    n;
    int    gap;

    task automatic sort_words();
        data_t key;
        int    j;
        for (int i = 1; i < WORD_COUNT; i++) begin
            key = words[i];
            j   = i - 1;
            while (j >= 0 && words[j] > key) begin
                words[j + 1] = words[j];
                j--;
            end
            words[j + 1] = key;
        end
    endtask

    initial begin
        seed        = SEED;
        ss_tready_o = 1'b0;
        sm_tvalid_o = 1'b0;
        sm_tdata_o  = '0;
        done_o      = 1'b0;
        forever begin
            @(posedge wb_clk_i);
            if (start_i && !wb_rst_i) begin
                #1;
                ss_tready_o = 1'b1;
                n = 0;
                while (n < WORD_COUNT) begin
                    @(posedge wb_clk_i);
                    if (ss_tvalid_i) begin
                        words[n] = ss_tdata_i;
                        n++;
                    end
                end
                #1;
                ss_tready_o = 1'b0;
                sort_words();
                for (int k = 0; k < WORD_COUNT; k++) begin
                    gap = $random(seed) & 3;
                    sm_tvalid_o = 1'b0;
                    if (gap != 0) begin
                        repeat (gap) @(posedge wb_clk_i);
                        #1;
                    end
                    sm_tvalid_o = 1'b1;
                    sm_tdata_o  = words[k];
                    @(posedge wb_clk_i);
                    while (!sm_tready_i) @(posedge wb_clk_i);
                    #1;
                end
                sm_tvalid_o = 1'b0;
                done_o      = 1'b1;
                @(posedge wb_clk_i);
                #1;
                done_o = 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_dma_qs.sv
`timescale 1ns/100ps

module tb_dma_qs;
    import dma_qs_pkg::*;

    localparam qs_addr_t BASE      = 24'h000040;
    localparam int       BASE_WORD = 16;  // BASE in words
    localparam int       SEED      = 32'h26e232eb;
    // Ten words with two accesses of up to 8 cycles each, Wishbone traffic, fourfold slack
    localparam int       TIMEOUT_CYCLES = 4 * (WORD_COUNT * 2 * 8 + 340);

    logic        wb_clk = 1'b0;
    logic        wb_rst;
    logic        wbs_stb, wbs_cyc, wbs_we, wbs_ack;
    logic [3:0]  wbs_sel;
    logic [31:0] wbs_adr;
    data_t       wbs_wdat, wbs_rdat;
    qs_addr_t    qs_address;
    data_t       qs_wdata, qs_rdata, ss_tdata, sm_tdata;
    logic        qs_rw, qs_busy, qs_in_valid, qs_out_valid, qs_prefetch_step;
    logic        qs_start, qs_done, ss_tvalid, ss_tready, sm_tvalid, sm_tready;

    int    errors, tests_run, tests_failed, cycle_count;
    int    start_count, rd_idx, wr_idx, ss_idx;
    logic  access_open;
    data_t in_words [WORD_COUNT];

    always #5 wb_clk = ~wb_clk;

    dma_qs_top i_dma_qs_top (
        .wb_clk_i(wb_clk), .wb_rst_i(wb_rst),
        .wbs_stb_i(wbs_stb), .wbs_cyc_i(wbs_cyc), .wbs_we_i(wbs_we), .wbs_sel_i(wbs_sel),
        .wbs_dat_i(wbs_wdat), .wbs_adr_i(wbs_adr), .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_rdat),
        .qs_address_o(qs_address), .qs_rw_o(qs_rw), .qs_wdata_o(qs_wdata),
        .qs_rdata_i(qs_rdata), .qs_busy_i(qs_busy), .qs_in_valid_o(qs_in_valid),
        .qs_out_valid_i(qs_out_valid), .qs_prefetch_step_o(qs_prefetch_step),
        .qs_start_o(qs_start), .qs_done_i(qs_done),
        .ss_tvalid_o(ss_tvalid), .ss_tdata_o(ss_tdata), .ss_tready_i(ss_tready),
        .sm_tvalid_i(sm_tvalid), .sm_tdata_i(sm_tdata), .sm_tready_o(sm_tready)
    );

    sdram_model #(.SEED(SEED)) i_sdram_model (
        .wb_clk_i(wb_clk), .wb_rst_i(wb_rst), .address_i(qs_address), .rw_i(qs_rw),
        .wdata_i(qs_wdata), .in_valid_i(qs_in_valid), .rdata_o(qs_rdata),
        .busy_o(qs_busy), .out_valid_o(qs_out_valid)
    );

    sort_engine_model #(.SEED(SEED)) i_sort_engine_model (
        .wb_clk_i(wb_clk), .wb_rst_i(wb_rst), .start_i(qs_start),
        .ss_tvalid_i(ss_tvalid), .ss_tdata_i(ss_tdata), .ss_tready_o(ss_tready),
        .sm_tvalid_o(sm_tvalid), .sm_tdata_o(sm_tdata), .sm_tready_i(sm_tready),
        .done_o(qs_done)
    );

    function automatic qs_addr_t word_addr(input int idx);
        return BASE + qs_addr_t'(idx * WORD_BYTES);
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("mismatch %0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input data_t dat);
        @(posedge wb_clk);
        #1;
        wbs_adr  = {24'h0, adr};
        wbs_wdat = dat;
        wbs_we   = 1'b1;
        wbs_stb  = 1'b1;
        wbs_cyc  = 1'b1;
        @(posedge wb_clk);
        while (!wbs_ack) @(posedge wb_clk);
        #1;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output data_t dat);
        @(posedge wb_clk);
        #1;
        wbs_adr = {24'h0, adr};
        wbs_we  = 1'b0;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        @(posedge wb_clk);
        while (!wbs_ack) @(posedge wb_clk);
        dat = wbs_rdat;
        #1;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    task automatic check_results();
        data_t got;
        data_t prev;
        int    hits;
        prev = '0;
        for (int j = 0; j < WORD_COUNT; j++) begin
            got  = i_sdram_model.mem[BASE_WORD + j];
            hits = 0;
            for (int i = 0; i < WORD_COUNT; i++)
                if (in_words[i] == got)
                    hits++;
            a_sorted: assert (j == 0 || got > prev)
                else flag_mismatch($sformatf("word at 0x%06h out of order", word_addr(j)));
            a_from_input: assert (hits == 1)
                else flag_mismatch($sformatf("result 0x%08h is not an input word", got));
            prev = got;
        end
    endtask

    // SDRAM port and stream monitors
    always @(posedge wb_clk) begin
        if (!wb_rst) begin
            if (qs_start)
                start_count++;
            if (qs_in_valid) begin
                a_one_open: assert (!access_open)
                    else flag_mismatch("in_valid while an access is outstanding");
                if (qs_rw) begin
                    a_wr_addr: assert (wr_idx < WORD_COUNT && qs_address == word_addr(wr_idx))
                        else flag_mismatch($sformatf("write %0d to 0x%06h", wr_idx, qs_address));
                    wr_idx++;
                end else begin
                    a_rd_addr: assert (rd_idx < WORD_COUNT && qs_address == word_addr(rd_idx))
                        else flag_mismatch($sformatf("read %0d from 0x%06h", rd_idx, qs_address));
                    a_prefetch: assert (qs_prefetch_step == (rd_idx != 0))
                        else flag_mismatch($sformatf("prefetch_step wrong on read %0d", rd_idx));
                    rd_idx++;
                end
                access_open = 1'b1;
            end else if (qs_out_valid) begin
                access_open = 1'b0;
            end
            if (ss_tvalid && ss_tready) begin
                a_ss_word: assert (ss_idx < WORD_COUNT && ss_tdata == in_words[ss_idx])
                    else flag_mismatch($sformatf("stream word %0d = 0x%08h", ss_idx, ss_tdata));
                ss_idx++;
            end
        end
    end

    a_ack_next: assert property (@(posedge wb_clk) disable iff (wb_rst)
        wbs_stb && wbs_cyc && !wbs_ack |=> wbs_ack)
        else flag_mismatch("no ack one cycle after the request");
    a_ack_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
        wbs_ack |=> !wbs_ack)
        else flag_mismatch("ack longer than one cycle");
    a_issue_idle: assert property (@(posedge wb_clk) disable iff (wb_rst)
        qs_in_valid |-> !qs_busy)
        else flag_mismatch("in_valid while controller busy");

    always @(posedge wb_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        data_t rd;
        int    err0;
        wb_rst      = 1'b1;
        wbs_stb     = 1'b0;
        wbs_cyc     = 1'b0;
        wbs_we      = 1'b0;
        wbs_sel     = 4'hf;
        wbs_adr     = '0;
        wbs_wdat    = '0;
        access_open = 1'b0;
        repeat (5) @(posedge wb_clk);
        #1;
        wb_rst = 1'b0;

        err0 = errors;
        wb_read(REG_CTRL, rd);
        a_reset_status: assert (rd[STAT_IDLE_BIT] && !rd[STAT_DONE_BIT])
            else flag_mismatch($sformatf("status after reset 0x%08h", rd));
        report_test("reset_status", err0);

        err0 = errors;
        wb_write(REG_CTRL, 32'h1);  // No base written yet
        wb_read(REG_CTRL, rd);
        a_start_ignored: assert (rd[STAT_IDLE_BIT] && start_count == 0)
            else flag_mismatch("start without a base address was accepted");
        report_test("start_without_base", err0);

        err0 = errors;
        wb_write(REG_BASE, data_t'(BASE));
        wb_read(REG_BASE, rd);
        a_base_readback: assert (rd == data_t'(BASE))
            else flag_mismatch($sformatf("base read back as 0x%08h", rd));
        report_test("base_readback", err0);

        err0 = errors;
        for (int i = 0; i < WORD_COUNT; i++)
            in_words[i] = i_sdram_model.mem[BASE_WORD + i];
        wb_write(REG_CTRL, 32'h1);
        rd = '0;
        while (!rd[STAT_DONE_BIT])
            wb_read(REG_CTRL, rd);  // Poll for the sticky done bit
        a_job_counts: assert (rd_idx == WORD_COUNT && wr_idx == WORD_COUNT
                              && ss_idx == WORD_COUNT && start_count == 1)
            else flag_mismatch($sformatf("job counts rd %0d wr %0d ss %0d start %0d",
                                         rd_idx, wr_idx, ss_idx, start_count));
        check_results();
        report_test("sort_job", err0);

        err0 = errors;
        wb_read(REG_CTRL, rd);
        a_done_clear: assert (!rd[STAT_DONE_BIT] && rd[STAT_IDLE_BIT])
            else flag_mismatch($sformatf("status after done read 0x%08h", rd));
        report_test("done_clear", err0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: compile.f
design/dma_qs_pkg.sv
design/dma_wb_regs.sv
design/dma_fetch.sv
design/dma_drain.sv
design/dma_sdram_arb.sv
design/dma_qs_top.sv
dv/tb_models.sv
dv/tb_dma_qs.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_dma_qs -Mdir build -o sim
./build/sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
